// ==== Bender.yml ====
package:
  name: clic

sources:
  - include_dirs:
      - source
    files:
      - source/clic_pkg.sv
      - source/clic_regs.sv
      - source/clic_gateway.sv
      - source/clic_arbiter.sv
      - source/clic.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/clic_tb.sv

// ==== clic.f ====
+incdir+source
source/clic_pkg.sv
source/clic_regs.sv
source/clic_gateway.sv
source/clic_arbiter.sv
source/clic.sv
dv/clic_tb.sv

// ==== dv/clic_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "clic_params.svh"

module clic_tb;

  localparam logic [1:0] op_write = 2'd0;
  localparam logic [1:0] op_read = 2'd1;
  localparam logic [1:0] op_irpt = 2'd2;
  localparam logic [1:0] op_noready = 2'd3;
  localparam int rounds = 40;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [15:0] irpt;
    logic [31:0] rdata;
    logic        meip;
    logic [11:0] meid;
  } row_t;

  logic clock;
  logic reset;
  logic clic_valid;
  logic [31:0] clic_addr;
  logic [31:0] clic_wdata;
  logic [3:0] clic_wstrb;
  logic [`CLIC_NUM_INT-1:0] clic_irpt;
  logic [31:0] clic_rdata;
  logic clic_ready;
  logic clic_meip;
  logic [`CLIC_ID_W-1:0] clic_meid;

  row_t rows [$];
  int cycles = 0;
  int cycle_limit = 0;
  logic [15:0] lfsr = 16'd70;
  logic [7:0] ctl_m [`CLIC_NUM_INT];
  logic en_m [`CLIC_NUM_INT];
  logic [3:0] nl_m;

  clic clic_inst (
    .clock      (clock),
    .reset      (reset),
    .clic_valid (clic_valid),
    .clic_addr  (clic_addr),
    .clic_wdata (clic_wdata),
    .clic_wstrb (clic_wstrb),
    .clic_rdata (clic_rdata),
    .clic_ready (clic_ready),
    .clic_meip  (clic_meip),
    .clic_meid  (clic_meid),
    .clic_irpt  (clic_irpt)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("run exceeded its cycle limit of %0d cycles", cycle_limit);
      stop_failed();
    end
  end

  // ========================================
  // helpers.
  // ========================================

  task automatic stop_failed();
    $display("=== FAIL ===");
    $fatal(1, "stopping the run");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, expected);
      stop_failed();
    end
  endtask

  task automatic add_row(input logic [1:0] op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] wstrb,
                         input logic [15:0] irpt, input logic [31:0] rdata,
                         input logic meip, input logic [11:0] meid);
    rows.push_back({op, addr, wdata, wstrb, irpt, rdata, meip, meid});
  endtask

  // fibonacci lfsr, taps 16 14 13 11.
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      val = {val[30:0], lfsr[0]};
    end
  endtask

  // called at a falling edge, returns at a falling edge.
  task automatic bus_request(input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] s, output logic [31:0] data);
    int waited;
    waited = 0;
    clic_valid = 1'b1;
    clic_addr = a;
    clic_wdata = d;
    clic_wstrb = s;
    @(negedge clock);
    clic_valid = 1'b0;
    clic_wstrb = '0;
    while (!clic_ready && waited < 4) begin
      @(negedge clock);
      waited++;
    end
    if (!clic_ready) begin
      $display("no ready response to the request at address 0x%h", a);
      stop_failed();
    end
    data = clic_rdata;
    @(negedge clock);
    check_value("clic_ready", 32'(clic_ready), 32'd0);
  endtask

  task automatic bus_no_ready(input logic [31:0] a);
    clic_valid = 1'b1;
    clic_addr = a;
    clic_wstrb = '0;
    repeat (3) begin
      @(negedge clock);
      clic_valid = 1'b0;
      check_value("clic_ready", 32'(clic_ready), 32'd0);
    end
  endtask

  task automatic set_inputs(input logic [15:0] v);
    clic_irpt = v;
    // four register stages to the pins.
    repeat (6) @(negedge clock);
  endtask

  // level in the high byte, priority in the low byte.
  function automatic logic [15:0] decode_ctl(input logic [7:0] c, input logic [3:0] nl);
    int n;
    logic [7:0] lvl;
    logic [7:0] pri;
    n = (nl > 4'd8) ? 8 : int'(nl);
    for (int b = 0; b < 8; b++) begin
      lvl[b] = (b >= 8 - n) ? c[b] : 1'b1;
      pri[b] = (b >= n) ? c[b - n] : 1'b1;
    end
    return {lvl, pri};
  endfunction

  function automatic logic [11:0] expected_winner(input logic [15:0] irpt);
    logic [15:0] best;
    logic [15:0] lp;
    logic [11:0] id;
    best = '0;
    id = '0;
    for (int i = 1; i < `CLIC_NUM_INT; i++) begin
      if (irpt[i] && en_m[i]) begin
        lp = decode_ctl(ctl_m[i], nl_m);
        if (lp > best) begin
          best = lp;
          id = 12'(i);
        end
      end
    end
    return id;
  endfunction

  // ========================================
  // stimulus table.
  // ========================================

  task automatic build_table();
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_0004, 32'h0000_0000, 4'h0, 16'h0000, 32'h0100_0010, 1'b0, 12'd0);
    add_row(op_noready,  32'h0000_0008, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_noready,  32'h0000_1040, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    // nmbits 3, nlbits 4, nvbits 1.
    add_row(op_write,    32'h0000_0000, 32'h0000_0069, 4'h1, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h69, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_100c, 32'ha5e1_ff01, 4'hf, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_100c, 32'h0000_0000, 4'h0, 16'h0000, 32'ha5c1_0100, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_100c, 32'h3c00_0000, 4'h8, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_100c, 32'h0000_0000, 4'h0, 16'h0000, 32'h3cc1_0100, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_100c, 32'h0000_0000, 4'h2, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_100c, 32'h0000_0000, 4'h0, 16'h0000, 32'h3cc1_0000, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_100c, 32'h0000_0000, 4'h4, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_100c, 32'h0000_0000, 4'h0, 16'h0000, 32'h3c00_0000, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_100c, 32'h0000_0100, 4'h2, 16'h0000, 32'h0, 1'b0, 12'd0);
    // level mode, id 5 still disabled.
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0008, 32'h0, 1'b1, 12'd3);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0020, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    // arbitration.
    add_row(op_write,    32'h0000_1014, 32'h5c00_0100, 4'ha, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0028, 32'h0, 1'b1, 12'd5);
    add_row(op_write,    32'h0000_0000, 32'h0000_0002, 4'h1, 16'h0028, 32'h0, 1'b0, 12'd0);
    // levels tie, the higher id has the higher priority.
    add_row(op_write,    32'h0000_100c, 32'h1c00_0000, 4'h8, 16'h0028, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0028, 32'h0, 1'b1, 12'd5);
    add_row(op_write,    32'h0000_100c, 32'h5c00_0000, 4'h8, 16'h0028, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0028, 32'h0, 1'b1, 12'd3);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    // rising edge on id 7.
    add_row(op_write,    32'h0000_101c, 32'h9002_0100, 4'he, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0080, 32'h0, 1'b1, 12'd7);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b1, 12'd7);
    add_row(op_read,     32'h0000_101c, 32'h0000_0000, 4'h0, 16'h0000, 32'h9002_0101, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_101c, 32'h0000_0000, 4'h1, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_101c, 32'h0000_0000, 4'h0, 16'h0000, 32'h9002_0100, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_101c, 32'h0000_0001, 4'h1, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_101c, 32'h0000_0000, 4'h0, 16'h0000, 32'h9002_0101, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_101c, 32'h0000_0000, 4'h1, 16'h0000, 32'h0, 1'b0, 12'd0);
    // falling edge on id 7.
    add_row(op_write,    32'h0000_101c, 32'h0006_0000, 4'h4, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0080, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b1, 12'd7);
    add_row(op_read,     32'h0000_101c, 32'h0000_0000, 4'h0, 16'h0000, 32'h9006_0101, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_101c, 32'h0000_0000, 4'h1, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_irpt,     32'h0000_0000, 32'h0000_0000, 4'h0, 16'h0000, 32'h0, 1'b0, 12'd0);
    // back to level, software set is ignored.
    add_row(op_write,    32'h0000_101c, 32'h0000_0000, 4'h4, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_write,    32'h0000_101c, 32'h0000_0001, 4'h1, 16'h0000, 32'h0, 1'b0, 12'd0);
    add_row(op_read,     32'h0000_101c, 32'h0000_0000, 4'h0, 16'h0000, 32'h9000_0100, 1'b0, 12'd0);
  endtask

  // ========================================
  // main sequence.
  // ========================================

  initial begin
    row_t r;
    logic [31:0] got;
    logic [31:0] val;
    logic [31:0] word;
    logic [11:0] exp_id;
    int id;
    reset = 1'b0;
    clic_valid = 1'b0;
    clic_addr = '0;
    clic_wdata = '0;
    clic_wstrb = '0;
    clic_irpt = '0;
    build_table();
    cycle_limit = rows.size() * 8 + rounds * 12;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    check_value("clic_ready", 32'(clic_ready), 32'd0);

    foreach (rows[i]) begin
      r = rows[i];
      case (r.op)
        op_write, op_read: begin
          bus_request(r.addr, r.wdata, r.wstrb, got);
          check_value("clic_rdata", got, r.rdata);
        end
        op_irpt: begin
          set_inputs(r.irpt);
          check_value("clic_meip", 32'(clic_meip), 32'(r.meip));
          check_value("clic_meid", 32'(clic_meid), 32'(r.meid));
        end
        default: begin
          bus_no_ready(r.addr);
        end
      endcase
    end

    // random control bytes and enables, all level mode.
    for (int i = 1; i < `CLIC_NUM_INT; i++) begin
      draw_bits(9, val);
      ctl_m[i] = val[8:1];
      en_m[i] = val[0];
      word = {val[8:1], 8'h00, 7'd0, val[0], 8'h00};
      bus_request(`CLIC_INT_BASE + 4 * i, word, 4'he, got);
    end

    for (int k = 0; k < rounds; k++) begin
      draw_bits(4, val);
      nl_m = val[3:0];
      bus_request(`CLIC_CFG_ADDR, {27'd0, nl_m, 1'b0}, 4'h1, got);
      draw_bits(4, val);
      id = int'(val[3:0]) % 15 + 1;
      draw_bits(9, val);
      ctl_m[id] = val[8:1];
      en_m[id] = val[0];
      word = {val[8:1], 8'h00, 7'd0, val[0], 8'h00};
      bus_request(`CLIC_INT_BASE + 4 * id, word, 4'ha, got);
      draw_bits(16, val);
      set_inputs(val[15:0]);
      exp_id = expected_winner(val[15:0]);
      check_value("clic_meip", 32'(clic_meip), 32'(exp_id != '0));
      check_value("clic_meid", 32'(clic_meid), 32'(exp_id));
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/clic.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "clic_params.svh"

module clic import clic_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     clic_valid,
  input  logic [31:0]              clic_addr,
  input  logic [31:0]              clic_wdata,
  input  logic [3:0]               clic_wstrb,
  output logic [31:0]              clic_rdata,
  output logic                     clic_ready,
  output logic                     clic_meip,
  output logic [`CLIC_ID_W-1:0]    clic_meid,
  input  logic [`CLIC_NUM_INT-1:0] clic_irpt
);

  logic [`CLIC_NUM_INT-1:0] pending;
  logic [`CLIC_NUM_INT-1:0] enable;
  logic [`CLIC_NUM_INT-1:0] ip_wr;
  logic ip_wdata;
  logic [3:0] nlbits;
  clic_attr_t attr [`CLIC_NUM_INT];
  logic [`CLIC_INTCTL_BITS-1:0] ctl [`CLIC_NUM_INT];

  clic_regs regs_inst (
    .clock    (clock),
    .reset    (reset),
    .valid    (clic_valid),
    .addr     (clic_addr),
    .wdata    (clic_wdata),
    .wstrb    (clic_wstrb),
    .pending  (pending),
    .rdata    (clic_rdata),
    .ready    (clic_ready),
    .nlbits   (nlbits),
    .enable   (enable),
    .attr     (attr),
    .ctl      (ctl),
    .ip_wr    (ip_wr),
    .ip_wdata (ip_wdata)
  );

  clic_gateway gateway_inst (
    .clock    (clock),
    .reset    (reset),
    .irpt     (clic_irpt),
    .attr     (attr),
    .ip_wr    (ip_wr),
    .ip_wdata (ip_wdata),
    .pending  (pending)
  );

  clic_arbiter arbiter_inst (
    .clock   (clock),
    .reset   (reset),
    .pending (pending),
    .enable  (enable),
    .ctl     (ctl),
    .nlbits  (nlbits),
    .meip    (clic_meip),
    .meid    (clic_meid)
  );

endmodule

`default_nettype wire

// ==== source/clic_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "clic_params.svh"

module clic_arbiter (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [`CLIC_NUM_INT-1:0]     pending,
  input  logic [`CLIC_NUM_INT-1:0]     enable,
  input  logic [`CLIC_INTCTL_BITS-1:0] ctl [`CLIC_NUM_INT],
  input  logic [3:0]                   nlbits,
  output logic                         meip,
  output logic [`CLIC_ID_W-1:0]        meid
);

  localparam int id_w = `CLIC_ID_W;
  localparam int cw = `CLIC_INTCTL_BITS;

  logic [3:0] n_eff;
  logic [cw-1:0] level [`CLIC_NUM_INT];
  logic [cw-1:0] prio [`CLIC_NUM_INT];
  logic [cw-1:0] level_q [`CLIC_NUM_INT];
  logic [cw-1:0] prio_q [`CLIC_NUM_INT];
  logic [id_w-1:0] best_id;
  logic [cw-1:0] best_level;
  logic [cw-1:0] best_prio;
  logic [id_w-1:0] winner_q;

  // ========================================
  // stage 1, decode and mask.
  // ========================================

  assign n_eff = (nlbits > 4'd8) ? 4'd8 : nlbits;

  // level keeps the top n bits, prio the rest shifted up, both padded with ones.
  always_comb begin
    for (int i = 0; i < `CLIC_NUM_INT; i++) begin
      if (pending[i] && enable[i]) begin
        level[i] = ctl[i] | ({cw{1'b1}} >> n_eff);
        prio[i] = (ctl[i] << n_eff) | ~({cw{1'b1}} << n_eff);
      end else begin
        level[i] = '0;
        prio[i] = '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      level_q <= '{default: '0};
      prio_q <= '{default: '0};
    end else begin
      level_q <= level;
      prio_q <= prio;
    end
  end

  // ========================================
  // stage 2, maximum search.
  // ========================================

  // id 0 skipped, ties keep the lower id.
  always_comb begin
    best_id = '0;
    best_level = '0;
    best_prio = '0;
    for (int i = 1; i < `CLIC_NUM_INT; i++) begin
      if ((level_q[i] > best_level) ||
          ((level_q[i] == best_level) && (prio_q[i] > best_prio))) begin
        best_id = id_w'(i);
        best_level = level_q[i];
        best_prio = prio_q[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      winner_q <= '0;
      meip <= 1'b0;
      meid <= '0;
    end else begin
      winner_q <= best_id;
      meip <= winner_q != '0;
      meid <= winner_q;
    end
  end

  meip_matches_meid: assert property (
    @(posedge clock) disable iff (!reset) meip == (meid != '0)
  );

endmodule

`default_nettype wire

// ==== source/clic_gateway.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "clic_params.svh"

module clic_gateway import clic_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`CLIC_NUM_INT-1:0] irpt,
  input  clic_attr_t               attr [`CLIC_NUM_INT],
  input  logic [`CLIC_NUM_INT-1:0] ip_wr,
  input  logic                     ip_wdata,
  output logic [`CLIC_NUM_INT-1:0] pending
);

  logic [`CLIC_NUM_INT-1:0] irpt_q;
  logic [`CLIC_NUM_INT-1:0] edge_hit;

  // edge in the direction each interrupt selects.
  always_comb begin
    for (int i = 0; i < `CLIC_NUM_INT; i++) begin
      if (attr[i].trig[1]) begin
        edge_hit[i] = irpt_q[i] & ~irpt[i];
      end else begin
        edge_hit[i] = ~irpt_q[i] & irpt[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      irpt_q <= '0;
      pending <= '0;
    end else begin
      irpt_q <= irpt;
      for (int i = 0; i < `CLIC_NUM_INT; i++) begin
        if (!attr[i].trig[0]) begin
          // level mode ignores software writes.
          pending[i] <= irpt[i];
        end else if (edge_hit[i]) begin
          pending[i] <= 1'b1;
        end else if (ip_wr[i]) begin
          pending[i] <= ip_wdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/clic_params.svh ====
`ifndef CLIC_PARAMS_SVH
`define CLIC_PARAMS_SVH

// ========================================
// interrupt sizes.
// ========================================

// id 0 is reserved for no interrupt.
`define CLIC_NUM_INT 16

`define CLIC_INTCTL_BITS 8

`define CLIC_ID_W 12

// ========================================
// register map byte offsets.
// ========================================

`define CLIC_CFG_ADDR 0

`define CLIC_INFO_ADDR 4

// one word per interrupt from here.
`define CLIC_INT_BASE 4096

`endif

// ==== source/clic_pkg.sv ====
`default_nettype none

package clic_pkg;

  // trig[0] selects edge mode, trig[1] the falling edge.
  typedef struct packed {
    logic [1:0] mode;
    logic [1:0] trig;
    logic       shv;
  } clic_attr_t;

  // same bit order as bits 6 to 0 of the bus word.
  typedef struct packed {
    logic [1:0] nmbits;
    logic [3:0] nlbits;
    logic       nvbits;
  } clic_cfg_t;

  typedef struct packed {
    logic [24:0] rsvd;
    clic_cfg_t   cfg;
  } clic_cfg_word_t;

  // per interrupt word.
  typedef struct packed {
    logic [7:0] ctl;
    logic [1:0] mode;
    logic [2:0] rsvd2;
    logic [1:0] trig;
    logic       shv;
    logic [6:0] rsvd1;
    logic       ie;
    logic [6:0] rsvd0;
    logic       ip;
  } clic_int_word_t;

  // address picks the view.
  typedef union packed {
    clic_cfg_word_t cfg;
    clic_int_word_t intr;
  } clic_word_u;

endpackage

`default_nettype wire

// ==== source/clic_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "clic_params.svh"

module clic_regs import clic_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         valid,
  input  logic [31:0]                  addr,
  input  logic [31:0]                  wdata,
  input  logic [3:0]                   wstrb,
  input  logic [`CLIC_NUM_INT-1:0]     pending,
  output logic [31:0]                  rdata,
  output logic                         ready,
  output logic [3:0]                   nlbits,
  output logic [`CLIC_NUM_INT-1:0]     enable,
  output clic_attr_t                   attr [`CLIC_NUM_INT],
  output logic [`CLIC_INTCTL_BITS-1:0] ctl [`CLIC_NUM_INT],
  output logic [`CLIC_NUM_INT-1:0]     ip_wr,
  output logic                         ip_wdata
);

  localparam int idx_w = $clog2(`CLIC_NUM_INT);
  localparam logic [31:0] cfg_addr = `CLIC_CFG_ADDR;
  localparam logic [31:0] info_addr = `CLIC_INFO_ADDR;
  localparam logic [31:0] int_base = `CLIC_INT_BASE;
  localparam logic [31:0] int_end = int_base + 32'(4 * `CLIC_NUM_INT);

  // triggers, ctl bits, versions, interrupt count.
  localparam logic [31:0] info_word = {1'b0, 6'd0, 4'(`CLIC_INTCTL_BITS), 8'd0,
                                       13'(`CLIC_NUM_INT)};

  clic_cfg_t cfg;
  clic_word_u wword;
  clic_word_u rword;
  logic sel_cfg;
  logic sel_info;
  logic sel_int;
  logic is_write;
  logic [idx_w-1:0] idx;

  // ========================================
  // decode.
  // ========================================

  assign wword = wdata;
  assign is_write = |wstrb;
  assign idx = addr[idx_w+1:2];

  assign sel_cfg = addr[31:2] == cfg_addr[31:2];
  assign sel_info = addr[31:2] == info_addr[31:2];
  assign sel_int = (addr >= int_base) && (addr < int_end);

  assign nlbits = cfg.nlbits;

  // ip itself lives in the gateway.
  assign ip_wdata = wword.intr.ip;

  always_comb begin
    ip_wr = '0;
    ip_wr[idx] = valid & is_write & sel_int & wstrb[0];
  end

  // ========================================
  // register writes.
  // ========================================

  always_ff @(posedge clock) begin
    if (!reset) begin
      cfg <= '0;
      enable <= '0;
      attr <= '{default: '0};
      ctl <= '{default: '0};
    end else if (valid && is_write) begin
      if (sel_cfg && wstrb[0]) begin
        cfg <= wword.cfg.cfg;
      end
      if (sel_int) begin
        if (wstrb[1]) begin
          enable[idx] <= wword.intr.ie;
        end
        if (wstrb[2]) begin
          attr[idx].mode <= wword.intr.mode;
          attr[idx].trig <= wword.intr.trig;
          attr[idx].shv <= wword.intr.shv;
        end
        if (wstrb[3]) begin
          ctl[idx] <= wword.intr.ctl;
        end
      end
    end
  end

  // ========================================
  // read data and response.
  // ========================================

  always_comb begin
    rword = '0;
    if (sel_cfg) begin
      rword.cfg.cfg = cfg;
    end else if (sel_info) begin
      rword = info_word;
    end else if (sel_int) begin
      rword.intr.ip = pending[idx];
      rword.intr.ie = enable[idx];
      rword.intr.shv = attr[idx].shv;
      rword.intr.trig = attr[idx].trig;
      rword.intr.mode = attr[idx].mode;
      rword.intr.ctl = ctl[idx];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
      rdata <= '0;
    end else begin
      ready <= valid & (sel_cfg | sel_info | sel_int);
      rdata <= '0;
      // writes return zero.
      if (valid && !is_write) begin
        rdata <= rword;
      end
    end
  end

  ready_follows_valid: assert property (
    @(posedge clock) disable iff (!reset) ready |-> $past(valid)
  );

  one_region: assert property (
    @(posedge clock) disable iff (!reset) valid |-> $onehot0({sel_cfg, sel_info, sel_int})
  );

endmodule

`default_nettype wire
